/* lpif_delay_line.sv */
// LPIF delay line
// fixed-depth register chain for a packed vector of level signals
// every bit shows up PIPE_STAGES cycles later, no enable

`timescale 1ns/100ps

module lpif_delay_line
#(
   parameter int WIDTH       = 1,
   parameter int PIPE_STAGES = 2
)
(
   input  logic             lclk,
   input  logic             reset,
   input  logic [WIDTH-1:0] i_din,
   output logic [WIDTH-1:0] o_dout
);

   logic [WIDTH-1:0] dly_q [0:PIPE_STAGES-1];

   always_ff @(posedge lclk or negedge reset)
   begin
      if (!reset)
      begin
         for (int i = 0; i < PIPE_STAGES; i++)
         begin
            dly_q[i] <= '0;                   // delayed outputs read zero
         end
      end
      else
      begin
         dly_q[0] <= i_din;
         for (int i = 1; i < PIPE_STAGES; i++)
         begin
            dly_q[i] <= dly_q[i-1];           // shift one step
         end
      end
   end

   assign o_dout = dly_q[PIPE_STAGES-1];

endmodule

/* lpif_flow_pipe.sv */
// LPIF flow pipe
// chain of single-entry stages between lp and lp prime, with push/pop
// flow control between stages and pl_trdy toward the link layer

`timescale 1ns/100ps

module lpif_flow_pipe
#(
   parameter int PIPE_STAGES = 2
)
(
   input  logic                 lclk,
   input  logic                 reset,

   input  logic                 i_irdy,
   input  lpif_pkg::lpif_valid_t  i_valid,
   input  lpif_pkg::lpif_data_t   i_data,
   input  lpif_pkg::lpif_crc_t    i_crc,
   input  lpif_pkg::lpif_stream_t i_stream,
   input  logic                 i_crc_valid,
   input  logic                 i_prime_trdy,
   input  lpif_pkg::lpif_state_t  i_state_sts,  // already delayed

   output logic                 o_trdy,
   output logic                 o_prime_trans_valid,
   output lpif_pkg::lpif_valid_t  o_prime_valid,
   output lpif_pkg::lpif_data_t   o_prime_data,
   output lpif_pkg::lpif_crc_t    o_prime_crc,
   output lpif_pkg::lpif_stream_t o_prime_stream,
   output logic                 o_prime_crc_valid
);

   import lpif_pkg::*;
   import lpif_pipe_pkg::*;

   localparam int LAST = PIPE_STAGES - 1;

   logic            stg_push   [0:PIPE_STAGES-1];
   logic            stg_pop    [0:PIPE_STAGES-1];
   logic            stg_ready  [0:PIPE_STAGES-1];
   logic            stg_empty  [0:PIPE_STAGES-1];
   lpif_flow_word_t stg_wrdata [0:PIPE_STAGES-1];
   lpif_flow_word_t stg_rddata [0:PIPE_STAGES-1];

   logic            in_valid;
   lpif_valid_t     prime_valid_raw;

   // upstream offers an item only with irdy and some valid bit
   assign in_valid = i_irdy & (|i_valid);

   //////////////////////////////////////////////////
   // push/pop chain, resolved from the tail back

   always_comb
   begin
      stg_pop[LAST] = ~stg_empty[LAST] & i_prime_trdy;    // leaves to pl prime
      for (int i = LAST; i > 0; i--)
      begin
         // a stage takes a new item when empty or draining this cycle
         stg_ready[i] = stg_empty[i] | stg_pop[i];
         stg_push[i]  = stg_ready[i] & ~stg_empty[i-1];
         stg_pop[i-1] = stg_push[i];                       // moves one stage on
      end
      stg_ready[0] = stg_empty[0] | stg_pop[0];
      stg_push[0]  = stg_ready[0] & in_valid;
   end

   //////////////////////////////////////////////////
   // stage chain

   for (genvar i = 0; i < PIPE_STAGES; i++)
   begin : gen_stage

      if (i == 0)
      begin : gen_head
         assign stg_wrdata[i] = {i_data,
                                 i_crc,
                                 i_stream,
                                 i_crc_valid,
                                 i_valid};
      end
      else
      begin : gen_body
         assign stg_wrdata[i] = stg_rddata[i-1];
      end

      lpif_pipe_stage u_stage
      (
         .lclk     (lclk),
         .reset    (reset),
         .i_push   (stg_push[i]),
         .i_pop    (stg_pop[i]),
         .i_wrdata (stg_wrdata[i]),
         .o_rddata (stg_rddata[i]),
         .o_empty  (stg_empty[i])
      );
   end

   //////////////////////////////////////////////////
   // ready toward lp, state gated

   assign o_trdy = stg_ready[0] & (i_state_sts == LPIF_STATE_ACTIVE);

   //////////////////////////////////////////////////
   // last stage onto lp prime

   assign {o_prime_data,
           o_prime_crc,
           o_prime_stream,
           o_prime_crc_valid,
           prime_valid_raw} = stg_rddata[LAST];

   assign o_prime_trans_valid = ~stg_empty[LAST];
   assign o_prime_valid       = stg_empty[LAST] ? '0 : prime_valid_raw;  // no stale valid

endmodule

/* lpif_pipe_pkg.sv */
// LPIF pipeline word layouts
// flow word carried by the pipe stages, and the widths of the packed
// lp sideband and pl status vectors carried by the delay lines

package lpif_pipe_pkg;

   // data, crc, stream, crc_valid, valid (msb to lsb)
   localparam int FLOW_WORD_WIDTH = $bits(lpif_pkg::lpif_data_t)   +
                                    $bits(lpif_pkg::lpif_crc_t)    +
                                    $bits(lpif_pkg::lpif_stream_t) +
                                    1                              + // crc_valid
                                    $bits(lpif_pkg::lpif_valid_t);

   typedef logic [FLOW_WORD_WIDTH-1:0] lpif_flow_word_t;

   // irdy, pri, state_req, cfg, cfg_vld, stallack, wake_req
   localparam int LP_SIDEBAND_WIDTH = 1 + $bits(lpif_pkg::lpif_pri_t) +
                                      $bits(lpif_pkg::lpif_state_t) +
                                      $bits(lpif_pkg::lpif_cfg_t) + 3;

   // valid, crc, data, crc_valid, stream, state_sts, lnk_up, error, stallreq, wake_ack
   localparam int PL_STATUS_WIDTH = $bits(lpif_pkg::lpif_valid_t) +
                                    $bits(lpif_pkg::lpif_crc_t) +
                                    $bits(lpif_pkg::lpif_data_t) + 1 +
                                    $bits(lpif_pkg::lpif_stream_t) +
                                    $bits(lpif_pkg::lpif_state_t) + 4;

endpackage

/* lpif_pipe_stage.sv */
// LPIF pipe stage
// single-entry holding register for one flow word, with empty flag
// push loads the word, pop without push frees the entry

`timescale 1ns/100ps

module lpif_pipe_stage
(
   input  logic                           lclk,
   input  logic                           reset,
   input  logic                           i_push,
   input  logic                           i_pop,
   input  lpif_pipe_pkg::lpif_flow_word_t i_wrdata,
   output lpif_pipe_pkg::lpif_flow_word_t o_rddata,
   output logic                           o_empty
);

   import lpif_pipe_pkg::*;

   lpif_flow_word_t word_q;                  // held item
   logic            full_q;

   // occupancy
   always_ff @(posedge lclk or negedge reset)
   begin
      if (!reset)
      begin
         full_q <= 1'b0;
      end
      else if (i_push)
      begin
         full_q <= 1'b1;                     // push wins over pop
      end
      else if (i_pop)
      begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge lclk)
   begin
      if (i_push)
      begin
         word_q <= i_wrdata;
      end
   end

   assign o_rddata = word_q;
   assign o_empty  = ~full_q;

endmodule

/* lpif_pipeline.sv */
// LPIF pipeline buffer
// flow-controlled lp data path plus fixed delay of lp sideband and
// pl status, all PIPE_STAGES deep, between link layer and phy layer

`timescale 1ns/100ps

module lpif_pipeline
#(
   parameter int PIPE_STAGES = 2               // at least 1
)
(
   input  logic                   lclk,
   input  logic                   reset,

   // lp side in
   input  lpif_pkg::lpif_valid_t  i_lp_valid,
   input  logic                   i_lp_irdy,
   input  lpif_pkg::lpif_pri_t    i_lp_pri,
   input  lpif_pkg::lpif_state_t  i_lp_state_req,
   input  lpif_pkg::lpif_cfg_t    i_lp_cfg,
   input  logic                   i_lp_cfg_vld,
   input  logic                   i_lp_stallack,
   input  logic                   i_lp_wake_req,
   input  lpif_pkg::lpif_data_t   i_lp_data,
   input  lpif_pkg::lpif_crc_t    i_lp_crc,
   input  lpif_pkg::lpif_stream_t i_lp_stream,
   input  logic                   i_lp_crc_valid,

   // lp prime out
   output logic                   o_lp_prime_trans_valid,
   output lpif_pkg::lpif_valid_t  o_lp_prime_valid,
   output lpif_pkg::lpif_data_t   o_lp_prime_data,
   output lpif_pkg::lpif_crc_t    o_lp_prime_crc,
   output lpif_pkg::lpif_stream_t o_lp_prime_stream,
   output logic                   o_lp_prime_crc_valid,
   output logic                   o_lp_prime_irdy,
   output lpif_pkg::lpif_pri_t    o_lp_prime_pri,
   output lpif_pkg::lpif_state_t  o_lp_prime_state_req,
   output lpif_pkg::lpif_cfg_t    o_lp_prime_cfg,
   output logic                   o_lp_prime_cfg_vld,
   output logic                   o_lp_prime_stallack,
   output logic                   o_lp_prime_wake_req,

   // pl prime in
   input  logic                   i_pl_prime_trdy,
   input  lpif_pkg::lpif_valid_t  i_pl_prime_valid,
   input  lpif_pkg::lpif_data_t   i_pl_prime_data,
   input  lpif_pkg::lpif_crc_t    i_pl_prime_crc,
   input  logic                   i_pl_prime_crc_valid,
   input  lpif_pkg::lpif_stream_t i_pl_prime_stream,
   input  lpif_pkg::lpif_state_t  i_pl_prime_state_sts,
   input  logic                   i_pl_prime_lnk_up,
   input  logic                   i_pl_prime_error,
   input  logic                   i_pl_prime_stallreq,
   input  logic                   i_pl_prime_wake_ack,

   // pl side out
   output logic                   o_pl_trdy,
   output lpif_pkg::lpif_valid_t  o_pl_valid,
   output lpif_pkg::lpif_data_t   o_pl_data,
   output lpif_pkg::lpif_crc_t    o_pl_crc,
   output logic                   o_pl_crc_valid,
   output lpif_pkg::lpif_stream_t o_pl_stream,
   output lpif_pkg::lpif_state_t  o_pl_state_sts,
   output logic                   o_pl_lnk_up,
   output logic                   o_pl_error,
   output logic                   o_pl_stallreq,
   output logic                   o_pl_wake_ack
);

   import lpif_pipe_pkg::*;

   //////////////////////////////////////////////////
   // lp data flow

   lpif_flow_pipe #(.PIPE_STAGES(PIPE_STAGES)) u_flow_pipe
   (
      .lclk                (lclk),
      .reset               (reset),
      .i_irdy              (i_lp_irdy),
      .i_valid             (i_lp_valid),
      .i_data              (i_lp_data),
      .i_crc               (i_lp_crc),
      .i_stream            (i_lp_stream),
      .i_crc_valid         (i_lp_crc_valid),
      .i_prime_trdy        (i_pl_prime_trdy),
      .i_state_sts         (o_pl_state_sts),      // delayed copy gates trdy
      .o_trdy              (o_pl_trdy),
      .o_prime_trans_valid (o_lp_prime_trans_valid),
      .o_prime_valid       (o_lp_prime_valid),
      .o_prime_data        (o_lp_prime_data),
      .o_prime_crc         (o_lp_prime_crc),
      .o_prime_stream      (o_lp_prime_stream),
      .o_prime_crc_valid   (o_lp_prime_crc_valid)
   );

   //////////////////////////////////////////////////
   // lp sideband delay

   lpif_delay_line #(.WIDTH(LP_SIDEBAND_WIDTH), .PIPE_STAGES(PIPE_STAGES)) u_lp_sideband_delay
   (
      .lclk   (lclk),
      .reset  (reset),
      .i_din  ({i_lp_irdy, i_lp_pri, i_lp_state_req, i_lp_cfg,
                i_lp_cfg_vld, i_lp_stallack, i_lp_wake_req}),
      .o_dout ({o_lp_prime_irdy, o_lp_prime_pri, o_lp_prime_state_req, o_lp_prime_cfg,
                o_lp_prime_cfg_vld, o_lp_prime_stallack, o_lp_prime_wake_req})
   );

   //////////////////////////////////////////////////
   // pl status delay

   lpif_delay_line #(.WIDTH(PL_STATUS_WIDTH), .PIPE_STAGES(PIPE_STAGES)) u_pl_status_delay
   (
      .lclk   (lclk),
      .reset  (reset),
      .i_din  ({i_pl_prime_valid, i_pl_prime_crc, i_pl_prime_data,
                i_pl_prime_crc_valid, i_pl_prime_stream, i_pl_prime_state_sts,
                i_pl_prime_lnk_up, i_pl_prime_error, i_pl_prime_stallreq,
                i_pl_prime_wake_ack}),
      .o_dout ({o_pl_valid, o_pl_crc, o_pl_data,
                o_pl_crc_valid, o_pl_stream, o_pl_state_sts,
                o_pl_lnk_up, o_pl_error, o_pl_stallreq,
                o_pl_wake_ack})
   );

endmodule

/* lpif_pkg.sv */
// LPIF field types
// widths of the link/physical layer fields and the link state codes
// shared by the pipeline buffer and its stages

package lpif_pkg;

   //////////////////////////////////////////////////
   // field widths

   localparam int LPIF_DATA_BYTES = 32;                // fixed 32 byte data path
   localparam int LPIF_CRC_BITS   = 16;
   localparam int LPIF_VALID_BITS = 1;                 // one valid per 32 bytes

   //////////////////////////////////////////////////
   // field types

   typedef logic [LPIF_DATA_BYTES*8-1:0] lpif_data_t;  // data bus
   typedef logic [LPIF_CRC_BITS-1:0]     lpif_crc_t;   // crc over data
   typedef logic [LPIF_VALID_BITS-1:0]   lpif_valid_t;
   typedef logic [7:0]                   lpif_stream_t; // stream id
   typedef logic [7:0]                   lpif_cfg_t;   // config byte
   typedef logic [1:0]                   lpif_pri_t;   // priority
   typedef logic [3:0]                   lpif_state_t; // state req / sts

   //////////////////////////////////////////////////
   // link state codes

   // pl_trdy is only given while the delayed state status shows this code
   localparam lpif_state_t LPIF_STATE_ACTIVE = 4'h1;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the LPIF pipeline testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_lpif_pipeline -o sim_lpif &&
./obj_dir/sim_lpif || exit 1

/* sources.f */
+incdir+.
lpif_pkg.sv
lpif_pipe_pkg.sv
lpif_pipe_stage.sv
lpif_flow_pipe.sv
lpif_delay_line.sv
lpif_pipeline.sv
tb_lpif_pipeline.sv

/* tb_lpif_ref.svh */
// LPIF pipeline reference functions
// expected delayed values and expected pl_trdy for the testbench model

`ifndef TB_LPIF_REF_SVH
`define TB_LPIF_REF_SVH

// oldest entry of a history that holds exactly PIPE_STAGES samples
function automatic logic [PL_W-1:0] expected_delayed(input logic [PL_W-1:0] hist[$]);
   logic [PL_W-1:0] oldest;
   oldest = '0;
   if (hist.size() > 0)
   begin
      oldest = hist[0];                       // sampled PIPE_STAGES edges ago
   end
   return oldest;
endfunction

// stage 0 can take an item and the delayed link state is active
function automatic logic expected_trdy(input logic ready0, input lpif_state_t state_dly);
   return ready0 && (state_dly == LPIF_STATE_ACTIVE);
endfunction

`endif

/* tb_lpif_pipeline.sv */
// LPIF pipeline buffer testbench
// random lp/pl stimulus, a cycle model of the stage chain, a scoreboard
// for ordered delivery and checks of both delay lines and pl_trdy

`timescale 1ns/100ps

module tb_lpif_pipeline;

   import lpif_pkg::*;
   import lpif_pipe_pkg::*;

   localparam int P    = 2;
   localparam int PL_W = PL_STATUS_WIDTH;

   `include "tb_lpif_ref.svh"

   logic lclk = 1'b0;
   logic reset;
   lpif_valid_t  i_lp_valid, o_lp_prime_valid, i_pl_prime_valid, o_pl_valid;
   logic         i_lp_irdy, i_lp_cfg_vld, i_lp_stallack, i_lp_wake_req, i_lp_crc_valid;
   lpif_pri_t    i_lp_pri, o_lp_prime_pri;
   lpif_state_t  i_lp_state_req, o_lp_prime_state_req, i_pl_prime_state_sts, o_pl_state_sts;
   lpif_cfg_t    i_lp_cfg, o_lp_prime_cfg;
   lpif_data_t   i_lp_data, o_lp_prime_data, i_pl_prime_data, o_pl_data;
   lpif_crc_t    i_lp_crc, o_lp_prime_crc, i_pl_prime_crc, o_pl_crc;
   lpif_stream_t i_lp_stream, o_lp_prime_stream, i_pl_prime_stream, o_pl_stream;
   logic o_lp_prime_trans_valid, o_lp_prime_crc_valid, o_lp_prime_irdy, o_lp_prime_cfg_vld;
   logic o_lp_prime_stallack, o_lp_prime_wake_req;
   logic i_pl_prime_trdy, i_pl_prime_crc_valid, i_pl_prime_lnk_up, i_pl_prime_error;
   logic i_pl_prime_stallreq, i_pl_prime_wake_ack;
   logic o_pl_trdy, o_pl_crc_valid, o_pl_lnk_up, o_pl_error, o_pl_stallreq, o_pl_wake_ack;

   // model state
   logic            m_full [0:P-1];
   logic [PL_W-1:0] lp_hist[$];
   logic [PL_W-1:0] pl_hist[$];
   lpif_flow_word_t sb_word[$];
   int              sb_cyc[$];
   logic            sb_rate[$];
   int              cyc = 0;
   logic            full_rate = 1'b0;
   lpif_state_t     cur_state = LPIF_STATE_ACTIVE;

   lpif_pipeline #(.PIPE_STAGES(P)) u_lpif_pipeline (.*);

   always #50 lclk = ~lclk;                   // 100 ns period

   task automatic check_value(input string name, input logic [PL_W-1:0] exp_v,
                              input logic [PL_W-1:0] act_v);
      assert (exp_v === act_v)
      else
      begin
         $display("** FAIL **");
         $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
         $fatal(1, "value check failed");
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("** FAIL **");
      $fatal(1, "timed out waiting for %s", what);
   endtask

   //////////////////////////////////////////////////
   // comparing process

   always @(posedge lclk)
   begin : compare
      logic [PL_W-1:0] exp_lp, exp_pl, cur_lp, cur_pl, act_lp, act_pl;
      logic            pop_m [0:P-1];
      logic            push_m [0:P-1];
      logic            rdy_m [0:P-1];
      logic            in_valid;
      lpif_flow_word_t in_word;
      cur_lp = PL_W'({i_lp_irdy, i_lp_pri, i_lp_state_req, i_lp_cfg, i_lp_cfg_vld,
                      i_lp_stallack, i_lp_wake_req});
      cur_pl = {i_pl_prime_valid, i_pl_prime_crc, i_pl_prime_data, i_pl_prime_crc_valid,
                i_pl_prime_stream, i_pl_prime_state_sts, i_pl_prime_lnk_up,
                i_pl_prime_error, i_pl_prime_stallreq, i_pl_prime_wake_ack};
      act_lp = PL_W'({o_lp_prime_irdy, o_lp_prime_pri, o_lp_prime_state_req, o_lp_prime_cfg,
                      o_lp_prime_cfg_vld, o_lp_prime_stallack, o_lp_prime_wake_req});
      act_pl = {o_pl_valid, o_pl_crc, o_pl_data, o_pl_crc_valid, o_pl_stream, o_pl_state_sts,
                o_pl_lnk_up, o_pl_error, o_pl_stallreq, o_pl_wake_ack};
      in_word = {i_lp_data, i_lp_crc, i_lp_stream, i_lp_crc_valid, i_lp_valid};
      in_valid = i_lp_irdy & (|i_lp_valid);
      exp_lp = expected_delayed(lp_hist);
      exp_pl = expected_delayed(pl_hist);
      if (!reset)
      begin
         for (int i = 0; i < P; i++)
         begin
            m_full[i] = 1'b0;
         end
         lp_hist = {};
         pl_hist = {};
         repeat (P) lp_hist.push_back('0);
         repeat (P) pl_hist.push_back('0);
         check_value("o_lp_prime_trans_valid", '0, PL_W'(o_lp_prime_trans_valid));
         check_value("o_lp_prime_valid", '0, PL_W'(o_lp_prime_valid));
         check_value("o_pl_trdy", '0, PL_W'(o_pl_trdy));
         check_value("lp sideband", '0, act_lp);
         check_value("pl status", '0, act_pl);
      end
      else
      begin
         check_value("lp sideband", exp_lp, act_lp);
         check_value("pl status", exp_pl, act_pl);
         // stage chain from the tail back to the head
         pop_m[P-1] = m_full[P-1] & i_pl_prime_trdy;
         for (int i = P-1; i >= 0; i--)
         begin
            rdy_m[i]  = ~m_full[i] | pop_m[i];
            push_m[i] = rdy_m[i] & ((i == 0) ? in_valid : m_full[(i > 0) ? i-1 : 0]);
            if (i > 0)
            begin
               pop_m[i-1] = push_m[i];
            end
         end
         check_value("o_pl_trdy", PL_W'(expected_trdy(rdy_m[0], exp_pl[7:4])),
                     PL_W'(o_pl_trdy));
         check_value("o_lp_prime_trans_valid", PL_W'(m_full[P-1]),
                     PL_W'(o_lp_prime_trans_valid));
         if (!o_lp_prime_trans_valid)
         begin
            check_value("o_lp_prime_valid", '0, PL_W'(o_lp_prime_valid));
         end
         if (pop_m[P-1])
         begin
            assert (sb_word.size() > 0)
            else
            begin
               $display("** FAIL **");
               $fatal(1, "item left the pipe with an empty scoreboard");
            end
            check_value("lp_prime item", PL_W'(sb_word[0]),
                        PL_W'({o_lp_prime_data, o_lp_prime_crc, o_lp_prime_stream,
                               o_lp_prime_crc_valid, o_lp_prime_valid}));
            if (sb_rate[0])
            begin
               check_value("item latency", PL_W'(P), PL_W'(cyc - sb_cyc[0]));
            end
            void'(sb_word.pop_front());
            void'(sb_cyc.pop_front());
            void'(sb_rate.pop_front());
         end
         if (push_m[0])
         begin
            sb_word.push_back(in_word);
            sb_cyc.push_back(cyc);
            sb_rate.push_back(full_rate);
         end
         for (int i = P-1; i >= 0; i--)
         begin
            if (push_m[i])
            begin
               m_full[i] = 1'b1;
            end
            else if (pop_m[i])
            begin
               m_full[i] = 1'b0;
            end
         end
         void'(lp_hist.pop_front());
         void'(pl_hist.pop_front());
         lp_hist.push_back(cur_lp);
         pl_hist.push_back(cur_pl);
      end
      cyc++;
   end

   //////////////////////////////////////////////////
   // stimulus

   task automatic drive_cycle(input logic trdy_high, input logic force_send);
      logic [31:0] r;
      @(negedge lclk);
      r = $urandom;
      i_pl_prime_trdy      = trdy_high | r[0] | r[1];
      i_lp_pri             = r[3:2];
      i_lp_state_req       = r[7:4];
      i_lp_cfg             = r[15:8];
      {i_lp_cfg_vld, i_lp_stallack, i_lp_wake_req, i_lp_crc_valid} = r[19:16];
      {i_pl_prime_crc_valid, i_pl_prime_lnk_up, i_pl_prime_error} = r[22:20];
      {i_pl_prime_stallreq, i_pl_prime_wake_ack, i_pl_prime_valid} = r[25:23];
      i_pl_prime_stream    = r[31:24];
      i_pl_prime_state_sts = cur_state;
      i_lp_data            = {8{$urandom}};
      i_pl_prime_data      = {8{$urandom}};
      r = $urandom;
      i_lp_crc             = r[15:0];
      i_pl_prime_crc       = r[31:16];
      r = $urandom;
      i_lp_stream          = r[7:0];
      #1;
      if (force_send)
      begin
         assert (o_pl_trdy)
         else
         begin
            $display("** FAIL **");
            $fatal(1, "pl_trdy dropped during a full-rate burst");
         end
      end
      i_lp_irdy  = o_pl_trdy & (force_send | r[8]);   // honour pl_trdy
      i_lp_valid = i_lp_irdy ? 1'b1 : r[9];
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (sb_word.size() != 0 || o_lp_prime_trans_valid)
      begin
         drive_cycle(1'b1, 1'b0);
         i_lp_irdy = 1'b0;
         n++;
         if (n > limit)
         begin
            timeout_fail("the pipe to drain");
         end
      end
   endtask

   task automatic gate_state(input lpif_state_t code, input logic exp_trdy);
      int n;
      cur_state = code;
      n = 0;
      do
      begin
         drive_cycle(1'b1, 1'b0);
         n++;
         if (n > 20)
         begin
            timeout_fail("pl_trdy to follow the state code");
         end
      end
      while (o_pl_trdy !== exp_trdy);
      // the first cycle only presents the new code
      check_value("pl_trdy state delay", PL_W'(P), PL_W'(n - 1));
   endtask

   initial
   begin
      void'($urandom(32'h0656_390a));
      reset = 1'b0;
      {i_lp_valid, i_lp_irdy, i_lp_pri, i_lp_state_req, i_lp_cfg, i_lp_cfg_vld} = '0;
      {i_lp_stallack, i_lp_wake_req, i_lp_data, i_lp_crc, i_lp_stream, i_lp_crc_valid} = '0;
      {i_pl_prime_trdy, i_pl_prime_valid, i_pl_prime_data, i_pl_prime_crc} = '0;
      {i_pl_prime_crc_valid, i_pl_prime_stream, i_pl_prime_state_sts} = '0;
      {i_pl_prime_lnk_up, i_pl_prime_error, i_pl_prime_stallreq, i_pl_prime_wake_ack} = '0;
      repeat (8) @(posedge lclk);
      @(negedge lclk);
      reset = 1'b1;

      repeat (400) drive_cycle(1'b0, 1'b0);     // random back-pressure
      wait_drained(50);

      full_rate = 1'b1;                         // back-to-back burst
      repeat (16) drive_cycle(1'b1, 1'b1);
      wait_drained(50);
      full_rate = 1'b0;

      gate_state(4'h3, 1'b0);
      gate_state(LPIF_STATE_ACTIVE, 1'b1);
      repeat (100) drive_cycle(1'b0, 1'b0);
      wait_drained(50);

      if (sb_word.size() == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
      begin
         $display("** FAIL **");
         $fatal(1, "scoreboard not empty at end of run");
      end
   end

endmodule
